// ==== aux_pkg.sv ====
`default_nettype none

package aux_pkg;

    ////////////////////////////////////////////////////////////
    // channel widths
    ////////////////////////////////////////////////////////////

    typedef logic [7:0]  aux_byte_t;
    typedef logic [19:0] aux_addr_t;
    // number of bytes minus one
    typedef logic [7:0]  aux_len_t;
    typedef logic [1:0]  aux_cmd_t;
    typedef logic [1:0]  aux_ack_t;

    // request commands
    localparam aux_cmd_t CMD_WRITE = 2'd0;
    localparam aux_cmd_t CMD_READ  = 2'd1;

    // high nibble of header byte 0
    localparam logic [3:0] NATIVE_WRITE_NIBBLE = 4'h8;
    localparam logic [3:0] NATIVE_READ_NIBBLE  = 4'h9;

    // ack codes, bits 5..4 of the first reply byte
    localparam aux_ack_t REPLY_ACK   = 2'd0;
    localparam aux_ack_t REPLY_NACK  = 2'd1;
    localparam aux_ack_t REPLY_DEFER = 2'd2;

    // reply wait and retransmission limits
    localparam int TIMEOUT_CYCLES = 200;
    localparam int MAX_RETRIES    = 3;

    ////////////////////////////////////////////////////////////
    // bundles
    ////////////////////////////////////////////////////////////

    typedef struct packed {
        aux_cmd_t  cmd;
        aux_addr_t address;
        aux_len_t  len;
        aux_byte_t data;
    } aux_request_t;

    typedef struct packed {
        aux_ack_t  ack;
        aux_byte_t data;
    } aux_reply_t;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_SEND,
        ST_WAIT,
        ST_REPLY,
        ST_RETRY
    } ctrl_state_t;

endpackage

`default_nettype wire

// ==== timeout_timer.sv ====
`timescale 1ns/1ps
`default_nettype none

module timeout_timer (
    input  logic clk,
    input  logic reset,
    input  logic msg_done,
    input  logic phy_start_stop,
    output logic timer_timeout
);
    import aux_pkg::*;

    logic                                    armed;
    logic [$clog2(TIMEOUT_CYCLES + 1) - 1:0] count;
    logic                                    expire;

    // count holds the cycles since msg_done
    assign expire = armed && !phy_start_stop && (int'(count) == TIMEOUT_CYCLES - 1);

    always_ff @(posedge clk) begin
        if (reset) begin
            armed         <= 1'b0;
            count         <= '0;
            timer_timeout <= 1'b0;
        end else begin
            timer_timeout <= expire;
            if (msg_done) begin
                armed <= 1'b1;
                count <= 1;
            end else if (phy_start_stop || expire) begin
                // sink answered, or the wait is over
                armed <= 1'b0;
                count <= '0;
            end else if (armed) begin
                count <= count + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== reply_decoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module reply_decoder (
    input  logic                clk,
    input  logic                reset,
    input  logic                phy_start_stop,
    input  aux_pkg::aux_byte_t  aux_in,
    output aux_pkg::aux_reply_t reply,
    output logic                reply_ack_vld,
    output logic                reply_data_vld
);

    logic phy_q;
    logic first_byte;
    logic next_byte;

    // first cycle of a start/stop run holds the ack byte
    assign first_byte = phy_start_stop && !phy_q;
    assign next_byte  = phy_start_stop && phy_q;

    always_ff @(posedge clk) begin
        if (reset) begin
            phy_q          <= 1'b0;
            reply_ack_vld  <= 1'b0;
            reply_data_vld <= 1'b0;
        end else begin
            phy_q          <= phy_start_stop;
            reply_ack_vld  <= first_byte;
            reply_data_vld <= next_byte;
        end
    end

    // ack code stays put while the data bytes go by
    always_ff @(posedge clk) begin
        if (first_byte) begin
            reply.ack <= aux_in[5:4];
        end else if (next_byte) begin
            reply.data <= aux_in;
        end
    end

endmodule

`default_nettype wire

// ==== native_message_encoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module native_message_encoder (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  ctrl_tr_vld,
    input  aux_pkg::aux_request_t ctrl_msg,
    output aux_pkg::aux_byte_t    aux_out,
    output logic                  aux_start_stop,
    output logic                  msg_done
);
    import aux_pkg::*;

    aux_request_t msg_q;
    logic         busy;
    logic [2:0]   idx;
    logic [2:0]   last_idx;
    logic [3:0]   cmd_nibble;
    aux_byte_t    hdr_byte;

    ////////////////////////////////////////////////////////////
    // byte select
    ////////////////////////////////////////////////////////////

    assign cmd_nibble = (msg_q.cmd == CMD_READ) ? NATIVE_READ_NIBBLE : NATIVE_WRITE_NIBBLE;

    // writes carry one extra data byte
    assign last_idx = (msg_q.cmd == CMD_WRITE) ? 3'd4 : 3'd3;

    always_comb begin
        case (idx)
            3'd0:    hdr_byte = {cmd_nibble, msg_q.address[19:16]};
            3'd1:    hdr_byte = msg_q.address[15:8];
            3'd2:    hdr_byte = msg_q.address[7:0];
            3'd3:    hdr_byte = (msg_q.cmd == CMD_WRITE) ? 8'h00 : msg_q.len;
            3'd4:    hdr_byte = msg_q.data;
            default: hdr_byte = 8'h00;
        endcase
    end

    assign aux_out        = busy ? hdr_byte : 8'h00;
    assign aux_start_stop = busy;
    assign msg_done       = busy && (idx == last_idx);

    ////////////////////////////////////////////////////////////
    // sequencing
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            busy <= 1'b0;
            idx  <= 3'd0;
        end else if (!busy) begin
            if (ctrl_tr_vld) begin
                busy <= 1'b1;
                idx  <= 3'd0;
            end
        end else if (msg_done) begin
            busy <= 1'b0;
            idx  <= 3'd0;
        end else begin
            idx <= idx + 1'b1;
        end
    end

    // request held for the whole message
    always_ff @(posedge clk) begin
        if (ctrl_tr_vld && !busy) begin
            msg_q <= ctrl_msg;
        end
    end

endmodule

`default_nettype wire

// ==== aux_ctrl_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module aux_ctrl_unit (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  spm_transaction_vld,
    input  aux_pkg::aux_request_t spm_request,
    input  logic                  lpm_transaction_vld,
    input  aux_pkg::aux_request_t lpm_request,
    input  aux_pkg::aux_reply_t   reply,
    input  logic                  reply_ack_vld,
    input  logic                  reply_data_vld,
    input  logic                  timer_timeout,
    input  logic                  msg_done,
    input  logic                  phy_start_stop,
    output logic                  ctrl_tr_vld,
    output aux_pkg::aux_request_t ctrl_msg,
    output aux_pkg::aux_reply_t   spm_reply,
    output logic                  spm_reply_ack_vld,
    output logic                  spm_reply_data_vld,
    output aux_pkg::aux_reply_t   lpm_reply,
    output logic                  lpm_reply_ack_vld,
    output logic                  lpm_reply_data_vld,
    output logic                  ctrl_native_failed
);
    import aux_pkg::*;

    ctrl_state_t                          state;
    aux_request_t                         req_q;
    logic                                 owner_lpm;
    logic [$clog2(MAX_RETRIES + 1) - 1:0] retry_cnt;
    logic                                 new_req;
    logic                                 retry_req;
    logic                                 reply_end;
    logic                                 routing_en;

    ////////////////////////////////////////////////////////////
    // arbitration, spm wins a tie
    ////////////////////////////////////////////////////////////

    assign new_req = (state == ST_IDLE) && (spm_transaction_vld || lpm_transaction_vld);

    // retransmit only once the sink has released the channel
    assign ctrl_tr_vld = new_req || ((state == ST_RETRY) && !phy_start_stop);

    always_comb begin
        if (state == ST_IDLE) begin
            ctrl_msg = spm_transaction_vld ? spm_request : lpm_request;
        end else begin
            ctrl_msg = req_q;
        end
    end

    always_ff @(posedge clk) begin
        if (new_req) begin
            req_q <= ctrl_msg;
        end
    end

    // reply classification while waiting
    always_comb begin
        retry_req = 1'b0;
        reply_end = 1'b0;
        if (state == ST_WAIT) begin
            if (reply_ack_vld) begin
                case (reply.ack)
                    REPLY_ACK, REPLY_NACK: reply_end = 1'b1;
                    REPLY_DEFER:           retry_req = 1'b1;
                    // reserved code closes it like a nack
                    default:               reply_end = 1'b1;
                endcase
            end else begin
                retry_req = timer_timeout;
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // transaction FSM
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            state              <= ST_IDLE;
            owner_lpm          <= 1'b0;
            retry_cnt          <= '0;
            ctrl_native_failed <= 1'b0;
        end else begin
            ctrl_native_failed <= 1'b0;
            case (state)
                ST_IDLE: begin
                    if (new_req) begin
                        owner_lpm <= !spm_transaction_vld;
                        retry_cnt <= '0;
                        state     <= ST_SEND;
                    end
                end
                ST_SEND: begin
                    if (msg_done) begin
                        state <= ST_WAIT;
                    end
                end
                ST_WAIT: begin
                    if (retry_req) begin
                        if (int'(retry_cnt) < MAX_RETRIES) begin
                            retry_cnt <= retry_cnt + 1'b1;
                            state     <= ST_RETRY;
                        end else begin
                            // out of attempts
                            ctrl_native_failed <= 1'b1;
                            state              <= ST_IDLE;
                        end
                    end else if (reply_end) begin
                        state <= ST_REPLY;
                    end
                end
                ST_REPLY: begin
                    // data bytes keep flowing until the sink drops start/stop
                    if (!phy_start_stop) begin
                        state <= ST_IDLE;
                    end
                end
                ST_RETRY: begin
                    if (!phy_start_stop) begin
                        state <= ST_SEND;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // reply routing to the owner
    assign routing_en = (state == ST_WAIT) || (state == ST_REPLY);

    assign spm_reply          = reply;
    assign spm_reply_ack_vld  = routing_en && !owner_lpm && reply_ack_vld;
    assign spm_reply_data_vld = routing_en && !owner_lpm && reply_data_vld;

    assign lpm_reply          = reply;
    assign lpm_reply_ack_vld  = routing_en && owner_lpm && reply_ack_vld;
    assign lpm_reply_data_vld = routing_en && owner_lpm && reply_data_vld;

endmodule

`default_nettype wire

// ==== aux_source_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module aux_source_top (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  spm_transaction_vld,
    input  aux_pkg::aux_request_t spm_request,
    input  logic                  lpm_transaction_vld,
    input  aux_pkg::aux_request_t lpm_request,
    input  logic                  phy_start_stop,
    input  aux_pkg::aux_byte_t    aux_in,
    output aux_pkg::aux_byte_t    aux_out,
    output logic                  aux_start_stop,
    output aux_pkg::aux_reply_t   spm_reply,
    output logic                  spm_reply_ack_vld,
    output logic                  spm_reply_data_vld,
    output aux_pkg::aux_reply_t   lpm_reply,
    output logic                  lpm_reply_ack_vld,
    output logic                  lpm_reply_data_vld,
    output logic                  ctrl_native_failed,
    output logic                  timer_timeout
);
    import aux_pkg::*;

    // control unit to encoder
    logic         ctrl_tr_vld;
    aux_request_t ctrl_msg;
    logic         msg_done;

    // decoder to control unit
    aux_reply_t   reply;
    logic         reply_ack_vld;
    logic         reply_data_vld;

    aux_ctrl_unit aux_ctrl_unit_inst (
        .clk                 (clk),
        .reset               (reset),
        .spm_transaction_vld (spm_transaction_vld),
        .spm_request         (spm_request),
        .lpm_transaction_vld (lpm_transaction_vld),
        .lpm_request         (lpm_request),
        .reply               (reply),
        .reply_ack_vld       (reply_ack_vld),
        .reply_data_vld      (reply_data_vld),
        .timer_timeout       (timer_timeout),
        .msg_done            (msg_done),
        .phy_start_stop      (phy_start_stop),
        .ctrl_tr_vld         (ctrl_tr_vld),
        .ctrl_msg            (ctrl_msg),
        .spm_reply           (spm_reply),
        .spm_reply_ack_vld   (spm_reply_ack_vld),
        .spm_reply_data_vld  (spm_reply_data_vld),
        .lpm_reply           (lpm_reply),
        .lpm_reply_ack_vld   (lpm_reply_ack_vld),
        .lpm_reply_data_vld  (lpm_reply_data_vld),
        .ctrl_native_failed  (ctrl_native_failed)
    );

    native_message_encoder native_message_encoder_inst (
        .clk            (clk),
        .reset          (reset),
        .ctrl_tr_vld    (ctrl_tr_vld),
        .ctrl_msg       (ctrl_msg),
        .aux_out        (aux_out),
        .aux_start_stop (aux_start_stop),
        .msg_done       (msg_done)
    );

    timeout_timer timeout_timer_inst (
        .clk            (clk),
        .reset          (reset),
        .msg_done       (msg_done),
        .phy_start_stop (phy_start_stop),
        .timer_timeout  (timer_timeout)
    );

    reply_decoder reply_decoder_inst (
        .clk            (clk),
        .reset          (reset),
        .phy_start_stop (phy_start_stop),
        .aux_in         (aux_in),
        .reply          (reply),
        .reply_ack_vld  (reply_ack_vld),
        .reply_data_vld (reply_data_vld)
    );

endmodule

`default_nettype wire

// ==== aux_source_properties.sv ====
`timescale 1ns/1ps
`default_nettype none

module aux_source_properties (
    input logic clk,
    input logic reset,
    input logic aux_start_stop,
    input logic spm_reply_ack_vld,
    input logic spm_reply_data_vld,
    input logic lpm_reply_ack_vld,
    input logic lpm_reply_data_vld,
    input logic ctrl_native_failed
);

    logic spm_any;
    logic lpm_any;

    assign spm_any = spm_reply_ack_vld || spm_reply_data_vld;
    assign lpm_any = lpm_reply_ack_vld || lpm_reply_data_vld;

    ////////////////////////////////////////////////////////////
    // top-level protocol
    ////////////////////////////////////////////////////////////

    // quiet outputs right after reset
    quiet_after_reset: assert property (@(posedge clk)
        reset |=> !aux_start_stop && !spm_any && !lpm_any && !ctrl_native_failed)
        else $error("outputs active in the cycle after reset");

    // a reply has exactly one owner
    one_owner: assert property (@(posedge clk) disable iff (reset)
        !(spm_any && lpm_any))
        else $error("spm and lpm reply strobes high together");

    failed_single_pulse: assert property (@(posedge clk) disable iff (reset)
        ctrl_native_failed |=> !ctrl_native_failed)
        else $error("ctrl_native_failed high on two consecutive cycles");

endmodule

bind aux_source_top aux_source_properties props_i (
    .clk                (clk),
    .reset              (reset),
    .aux_start_stop     (aux_start_stop),
    .spm_reply_ack_vld  (spm_reply_ack_vld),
    .spm_reply_data_vld (spm_reply_data_vld),
    .lpm_reply_ack_vld  (lpm_reply_ack_vld),
    .lpm_reply_data_vld (lpm_reply_data_vld),
    .ctrl_native_failed (ctrl_native_failed)
);

`default_nettype wire

// ==== tb_aux_source.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_aux_source;
    import aux_pkg::*;

    localparam int WATCHDOG_CYCLES = 20 * (TIMEOUT_CYCLES + 50);

    logic         clk = 1'b0;
    logic         reset;
    logic         spm_transaction_vld;
    aux_request_t spm_request;
    logic         lpm_transaction_vld;
    aux_request_t lpm_request;
    logic         phy_start_stop;
    aux_byte_t    aux_in;
    aux_byte_t    aux_out;
    logic         aux_start_stop;
    aux_reply_t   spm_reply;
    logic         spm_reply_ack_vld;
    logic         spm_reply_data_vld;
    aux_reply_t   lpm_reply;
    logic         lpm_reply_ack_vld;
    logic         lpm_reply_data_vld;
    logic         ctrl_native_failed;
    logic         timer_timeout;

    integer    seed = 9;
    int        errors = 0;
    int        checks = 0;
    // monitor state, cleared when clear_tog flips
    logic      clear_tog = 1'b0;
    logic      clear_seen = 1'b0;
    logic      start_stop_q = 1'b0;
    int        msg_count = 0;
    int        timeout_count = 0;
    int        failed_count = 0;
    aux_byte_t spm_acks[$];
    aux_byte_t spm_data[$];
    aux_byte_t lpm_acks[$];
    aux_byte_t lpm_data[$];
    // sink side
    aux_byte_t captured[$];
    aux_byte_t expected[$];
    aux_byte_t reply_bytes[$];
    aux_byte_t exp_acks[$];

    aux_source_top dut_i (.*);

    always #10 clk = ~clk;

    ////////////////////////////////////////////////////////////
    // output monitor, samples on the falling edge
    ////////////////////////////////////////////////////////////

    always @(negedge clk) begin
        start_stop_q <= aux_start_stop;
        if (clear_tog != clear_seen) begin
            clear_seen    <= clear_tog;
            msg_count     <= 0;
            timeout_count <= 0;
            failed_count  <= 0;
            spm_acks.delete();
            spm_data.delete();
            lpm_acks.delete();
            lpm_data.delete();
        end else if (!reset) begin
            if (aux_start_stop && !start_stop_q)
                msg_count <= msg_count + 1;
            if (timer_timeout)
                timeout_count <= timeout_count + 1;
            if (ctrl_native_failed)
                failed_count <= failed_count + 1;
            if (spm_reply_ack_vld)
                spm_acks.push_back(aux_byte_t'(spm_reply.ack));
            if (spm_reply_data_vld)
                spm_data.push_back(spm_reply.data);
            if (lpm_reply_ack_vld)
                lpm_acks.push_back(aux_byte_t'(lpm_reply.ack));
            if (lpm_reply_data_vld)
                lpm_data.push_back(lpm_reply.data);
        end
    end

    ////////////////////////////////////////////////////////////
    // helpers
    ////////////////////////////////////////////////////////////

    task automatic check_byte(input string what, input aux_byte_t got, input aux_byte_t exp);
        checks++;
        assert (got == exp) else begin
            errors++;
            $display("ERROR at %0d ns: %s is 0x%02h, expected 0x%02h", $time, what, got, exp);
        end
    endtask

    task automatic check_count(input string what, input int got, input int exp);
        checks++;
        assert (got == exp) else begin
            errors++;
            $display("ERROR at %0d ns: %s is %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic check_queue(input string what, input aux_byte_t got[$],
                               input aux_byte_t exp[$]);
        check_count({what, " count"}, got.size(), exp.size());
        if (got.size() == exp.size()) begin
            foreach (got[i]) begin
                check_byte($sformatf("%s[%0d]", what, i), got[i], exp[i]);
            end
        end
    endtask

    // all steps run 1 ns after the rising edge
    task automatic wait_cycles(input int n);
        repeat (n) @(posedge clk);
        #1;
    endtask

    task automatic clear_monitor();
        clear_tog = ~clear_tog;
    endtask

    task automatic random_request(input aux_cmd_t cmd, input aux_len_t len,
                                  output aux_request_t r);
        logic [31:0] rnd;
        rnd       = $random(seed);
        r.cmd     = cmd;
        r.address = rnd[19:0];
        r.len     = len;
        r.data    = rnd[27:20];
    endtask

    task automatic fill_reply_bytes(input int n);
        logic [31:0] rnd;
        reply_bytes.delete();
        repeat (n) begin
            rnd = $random(seed);
            reply_bytes.push_back(rnd[7:0]);
        end
    endtask

    // header bytes by the native read/write rules
    task automatic build_expected(input aux_request_t r);
        logic [3:0] nibble;
        nibble = (r.cmd == CMD_READ) ? NATIVE_READ_NIBBLE : NATIVE_WRITE_NIBBLE;
        expected.delete();
        expected.push_back({nibble, r.address[19:16]});
        expected.push_back(r.address[15:8]);
        expected.push_back(r.address[7:0]);
        if (r.cmd == CMD_READ) begin
            expected.push_back(r.len);
        end else begin
            expected.push_back(8'h00);
            expected.push_back(r.data);
        end
    endtask

    task automatic issue_request(input logic spm_vld, input aux_request_t spm_req,
                                 input logic lpm_vld, input aux_request_t lpm_req);
        spm_transaction_vld = spm_vld;
        spm_request         = spm_req;
        lpm_transaction_vld = lpm_vld;
        lpm_request         = lpm_req;
        wait_cycles(1);
        spm_transaction_vld = 1'b0;
        lpm_transaction_vld = 1'b0;
    endtask

    task automatic capture_message();
        captured.delete();
        @(negedge clk);
        while (!aux_start_stop) @(negedge clk);
        while (aux_start_stop) begin
            captured.push_back(aux_out);
            @(negedge clk);
        end
        wait_cycles(1);
    endtask

    // sink answer, ack byte then reply_bytes
    task automatic send_reply(input aux_ack_t ack);
        wait_cycles(10);
        phy_start_stop = 1'b1;
        aux_in         = {2'b00, ack, 4'h0};
        foreach (reply_bytes[i]) begin
            wait_cycles(1);
            aux_in = reply_bytes[i];
        end
        wait_cycles(1);
        phy_start_stop = 1'b0;
        aux_in         = 8'h00;
    endtask

    ////////////////////////////////////////////////////////////
    // tests
    ////////////////////////////////////////////////////////////

    task automatic test_after_reset();
        wait_cycles(5);
        check_count("aux_start_stop after reset", int'(aux_start_stop), 0);
        check_count("messages after reset", msg_count, 0);
        check_count("failures after reset", failed_count, 0);
        check_count("reply strobes after reset",
                    spm_acks.size() + spm_data.size() + lpm_acks.size() + lpm_data.size(), 0);
    endtask

    task automatic test_spm_read();
        aux_request_t req;
        clear_monitor();
        random_request(CMD_READ, 8'd2, req);
        build_expected(req);
        issue_request(1'b1, req, 1'b0, '0);
        capture_message();
        check_queue("spm read header", captured, expected);
        fill_reply_bytes(3);
        send_reply(REPLY_ACK);
        wait_cycles(5);
        exp_acks.delete();
        exp_acks.push_back(aux_byte_t'(REPLY_ACK));
        check_queue("spm read ack", spm_acks, exp_acks);
        check_queue("spm read data", spm_data, reply_bytes);
        check_count("lpm strobes in spm read", lpm_acks.size() + lpm_data.size(), 0);
    endtask

    task automatic test_lpm_write();
        aux_request_t req;
        clear_monitor();
        // len is not sent on a write
        random_request(CMD_WRITE, 8'h5a, req);
        build_expected(req);
        issue_request(1'b0, '0, 1'b1, req);
        capture_message();
        check_queue("lpm write header", captured, expected);
        reply_bytes.delete();
        send_reply(REPLY_ACK);
        wait_cycles(5);
        exp_acks.delete();
        exp_acks.push_back(aux_byte_t'(REPLY_ACK));
        check_queue("lpm write ack", lpm_acks, exp_acks);
        check_count("lpm write data strobes", lpm_data.size(), 0);
        check_count("spm strobes in lpm write", spm_acks.size() + spm_data.size(), 0);
    endtask

    task automatic test_tie_retry();
        aux_request_t spm_req;
        aux_request_t lpm_req;
        clear_monitor();
        random_request(CMD_READ, 8'd0, spm_req);
        random_request(CMD_WRITE, 8'd0, lpm_req);
        build_expected(spm_req);
        issue_request(1'b1, spm_req, 1'b1, lpm_req);
        capture_message();
        check_queue("tie winner header", captured, expected);
        reply_bytes.delete();
        send_reply(REPLY_DEFER);
        capture_message();
        check_queue("retransmitted header", captured, expected);
        fill_reply_bytes(1);
        send_reply(REPLY_ACK);
        wait_cycles(20);
        exp_acks.delete();
        exp_acks.push_back(aux_byte_t'(REPLY_DEFER));
        exp_acks.push_back(aux_byte_t'(REPLY_ACK));
        check_queue("tie spm acks", spm_acks, exp_acks);
        check_queue("tie spm data", spm_data, reply_bytes);
        check_count("lpm strobes in tie", lpm_acks.size() + lpm_data.size(), 0);
        // the losing lpm request is dropped
        check_count("messages in tie", msg_count, 2);
    endtask

    task automatic test_no_reply();
        aux_request_t req;
        clear_monitor();
        random_request(CMD_READ, 8'd15, req);
        build_expected(req);
        issue_request(1'b1, req, 1'b0, '0);
        for (int n = 0; n <= MAX_RETRIES; n++) begin
            capture_message();
            check_queue($sformatf("attempt %0d header", n), captured, expected);
            check_count($sformatf("timeouts before attempt %0d", n), timeout_count, n);
        end
        while (failed_count == 0) wait_cycles(1);
        wait_cycles(TIMEOUT_CYCLES + 20);
        check_count("messages without reply", msg_count, MAX_RETRIES + 1);
        check_count("timeouts without reply", timeout_count, MAX_RETRIES + 1);
        check_count("failure pulses", failed_count, 1);
    endtask

    ////////////////////////////////////////////////////////////
    // main sequence and watchdog
    ////////////////////////////////////////////////////////////

    initial begin
        reset               = 1'b1;
        spm_transaction_vld = 1'b0;
        spm_request         = '0;
        lpm_transaction_vld = 1'b0;
        lpm_request         = '0;
        phy_start_stop      = 1'b0;
        aux_in              = 8'h00;
        repeat (5) @(posedge clk);
        #1;
        reset = 1'b0;
        test_after_reset();
        test_spm_read();
        test_lpm_write();
        test_tie_retry();
        test_no_reply();
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("watchdog expired after %0d cycles, the DUT stopped responding",
                 WATCHDOG_CYCLES);
        $display("FAIL: see errors above");
        $finish;
    end

endmodule

`default_nettype wire

// ==== src.f ====
aux_pkg.sv
timeout_timer.sv
reply_decoder.sv
native_message_encoder.sv
aux_ctrl_unit.sv
aux_source_top.sv
aux_source_properties.sv
tb_aux_source.sv

// ==== run.sh ====
#!/bin/sh
# build and run the AUX source testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
    -f src.f --top-module tb_aux_source -o tb_aux_source
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/tb_aux_source > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^PASS: all tests$" "$LOG"; then
    exit 0
fi
echo "pass message not found in $LOG"
exit 1
